// File: Makefile
# Verilator build and run of the rs decoder testbench

SIM := obj_dir/Vtb_rs_decoder

.PHONY: run clean

run: $(SIM)
	$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "sim failed" sim.log; then exit 1; fi

$(SIM): list.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --assert --timing -Wno-fatal --top-module tb_rs_decoder -f list.f

clean:
	rm -rf obj_dir sim.log

// File: hw/rs_chien_forney.sv
//----------------------------------------
// chien search and forney correction
// root search, error values, result req/ack
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rs_chien_forney (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          loc_val,
  input  rs_pkg::loc_t  loc,
  output logic          loc_take,
  input  logic          correct_en,
  output logic          res_req,
  output rs_pkg::res_t  res,
  input  logic          res_ack,
  output rs_pkg::stat_t stat
);
  import rs_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SEARCH, ST_FIN} state_t;

  state_t       state;
  logic [3:0]   pos;
  logic         stat_done;
  sym_t         lterm [CHECK+1];   // lambda_k * alpha^(-k*pos)
  sym_t         oterm [CHECK];     // omega terms with the forney scale folded in
  sym_t [N-1:0] data, errv;
  logic         eras_fail, nonzero, fail;
  logic [3:0]   deg, loc_deg, nroots, ncorr;
  sym_t         lsum, lodd, osum, errval;

  // next word only once the host has released the last one
  assign loc_take = (state == ST_IDLE) && loc_val && !res_req && !res_ack;

  always_comb begin
    lsum    = '0;
    lodd    = '0;
    osum    = '0;
    loc_deg = '0;
    for (int k = 0; k <= CHECK; k++) begin
      lsum = lsum ^ lterm[k];
      if (k % 2 == 1) lodd = lodd ^ lterm[k];      // x * derivative
      if (loc.loc_poly[k] != '0) loc_deg = 4'(k);
    end
    for (int k = 0; k < CHECK; k++)
      osum = osum ^ oterm[k];
    errval = gf_mult(osum, gf_inv(lodd));
  end

  assign fail = eras_fail || (nroots != deg);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= ST_IDLE;
      pos       <= '0;
      res_req   <= 1'b0;
      stat_done <= 1'b0;
    end else begin
      stat_done <= 1'b0;
      if (res_ack) res_req <= 1'b0;
      case (state)
        ST_IDLE   : if (loc_take) begin
          state <= ST_SEARCH;
          pos   <= '0;
        end
        ST_SEARCH : begin
          pos <= pos + 1'b1;
          if (pos == 4'(N - 1)) state <= ST_FIN;
        end
        ST_FIN    : begin
          state     <= ST_IDLE;
          res_req   <= 1'b1;
          stat_done <= 1'b1;     // same cycle as res_req rise
        end
        default   : state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (loc_take) begin
      for (int k = 0; k <= CHECK; k++)
        lterm[k] <= loc.loc_poly[k];
      for (int k = 0; k < CHECK; k++)
        oterm[k] <= loc.omega[k];
      data      <= loc.cw.sym;
      errv      <= '0;
      eras_fail <= loc.eras_fail;
      nonzero   <= loc.nonzero;
      deg       <= loc_deg;
      nroots    <= '0;
      ncorr     <= '0;
    end else if (state == ST_SEARCH) begin
      for (int k = 0; k <= CHECK; k++)
        lterm[k] <= gf_mult(lterm[k], gf_alpha_pow(N - k));
      // X^-(CHECK+GENSTART) scale rides on the evaluator terms
      for (int k = 0; k < CHECK; k++)
        oterm[k] <= gf_mult(oterm[k], gf_alpha_pow(2*N - k - CHECK - GENSTART));
      if (lsum == '0) begin
        nroots    <= nroots + 1'b1;
        errv[pos] <= errval;
        if (errval != '0) ncorr <= ncorr + 1'b1;
      end
    end else if (state == ST_FIN) begin
      res.decfail <= fail;
      res.nonzero <= nonzero;
      if (correct_en && !fail) begin
        res.data    <= data ^ errv;
        res.num_err <= ncorr;
      end else begin
        res.data    <= data;        // pass through untouched
        res.num_err <= '0;
      end
    end
  end

  assign stat.done    = stat_done;
  assign stat.decfail = res.decfail;
  assign stat.num_err = res.num_err;

endmodule

`default_nettype wire

// File: hw/rs_decoder_regs.sv
//----------------------------------------
// control register and statistics counters
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rs_decoder_regs (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          cfg_we,
  input  logic [1:0]    cfg_addr,
  input  logic [31:0]   cfg_wdata,
  output logic [31:0]   cfg_rdata,
  input  rs_pkg::stat_t stat,
  output logic          correct_en
);
  import rs_pkg::*;

  logic [31:0] words;   // decoded words
  logic [31:0] fails;   // words with decfail
  logic [31:0] syms;    // corrected symbols

  // a write to a counter clears it
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      correct_en <= 1'b1;
      words      <= '0;
      fails      <= '0;
      syms       <= '0;
    end else begin
      if (cfg_we && cfg_addr == CFG_CTRL) correct_en <= cfg_wdata[0];
      if (cfg_we && cfg_addr == CFG_WORDS) words <= '0;
      else if (stat.done) words <= words + 1'b1;
      if (cfg_we && cfg_addr == CFG_FAILS) fails <= '0;
      else if (stat.done && stat.decfail) fails <= fails + 1'b1;
      if (cfg_we && cfg_addr == CFG_SYMS) syms <= '0;
      else if (stat.done) syms <= syms + 32'(stat.num_err);
    end
  end

  always_comb begin
    case (cfg_addr)
      CFG_CTRL  : cfg_rdata = {31'b0, correct_en};
      CFG_WORDS : cfg_rdata = words;
      CFG_FAILS : cfg_rdata = fails;
      default   : cfg_rdata = syms;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rs_decoder_top.sv
//----------------------------------------
// rs decoder top level
// syndrome, berlekamp, chien/forney, registers
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rs_decoder_top (
  input  logic         iclk,
  input  logic         ireset,
  input  logic         in_req,
  input  rs_pkg::cw_t  in_data,
  output logic         in_ack,
  output logic         res_req,
  output rs_pkg::res_t res,
  input  logic         res_ack,
  input  logic         cfg_we,
  input  logic [1:0]   cfg_addr,
  input  logic [31:0]  cfg_wdata,
  output logic [31:0]  cfg_rdata
);
  import rs_pkg::*;

  //----------------------------------------
  // stage links
  //----------------------------------------
  logic  syn_val, bm_ready;
  syn_t  syn;
  logic  loc_val, loc_take;
  loc_t  loc;
  stat_t stat;
  logic  correct_en;

  rs_syndrome i_rs_syndrome (
    .iclk     (iclk),
    .ireset   (ireset),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .bm_ready (bm_ready),
    .syn_val  (syn_val),
    .syn      (syn)
  );

  rs_eras_berlekamp i_rs_eras_berlekamp (
    .iclk     (iclk),
    .ireset   (ireset),
    .bm_ready (bm_ready),
    .syn_val  (syn_val),
    .syn      (syn),
    .loc_val  (loc_val),
    .loc      (loc),
    .loc_take (loc_take)
  );

  rs_chien_forney i_rs_chien_forney (
    .iclk       (iclk),
    .ireset     (ireset),
    .loc_val    (loc_val),
    .loc        (loc),
    .loc_take   (loc_take),
    .correct_en (correct_en),
    .res_req    (res_req),
    .res        (res),
    .res_ack    (res_ack),
    .stat       (stat)
  );

  rs_decoder_regs i_rs_decoder_regs (
    .iclk       (iclk),
    .ireset     (ireset),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .stat       (stat),
    .correct_en (correct_en)
  );

endmodule

`default_nettype wire

// File: hw/rs_eras_berlekamp.sv
//----------------------------------------
// erasure berlekamp stage
// reformulated inversionless BM with erasure init
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rs_eras_berlekamp (
  input  logic         iclk,
  input  logic         ireset,
  output logic         bm_ready,
  input  logic         syn_val,
  input  rs_pkg::syn_t syn,
  output logic         loc_val,
  output rs_pkg::loc_t loc,
  input  logic         loc_take
);
  import rs_pkg::*;

  typedef enum logic [2:0] {
    ST_WAIT,
    ST_EPOLY,   // erasure locator product
    ST_EDONE,   // seed BM from erasure locator
    ST_OMEGA,   // modified syndromes
    ST_BMINIT,
    ST_BMSTEP,
    ST_HOLD     // result parked until taken
  } state_t;

  state_t state, state_nxt;

  logic [3:0]       eras_num;
  logic             eras_fail, eras_zero, eras_max;
  logic [CNT_W-1:0] cnt, cnt_r_level;
  logic             cnt_done, cnt_r_done;
  logic             nonzero;
  cw_t              cw;

  sym_t l_poly [CHECK+1];   // locator
  sym_t b_poly [CHECK+1];
  sym_t gamma  [CHECK+1];   // discrepancies, evaluator at the end
  sym_t tetta  [CHECK+1];
  sym_t sh_reg [CHECK];
  sym_t sigma;
  sym_t kv;                 // signed step counter, msb is sign

  assign cnt_r_done = (cnt == cnt_r_level);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_WAIT   : if (syn_val) state_nxt = ST_EPOLY;
      ST_EPOLY  : if (cnt_done) state_nxt = ST_EDONE;
      ST_EDONE  : state_nxt = eras_zero ? ST_BMINIT : ST_OMEGA;
      ST_OMEGA  : if (cnt_r_done) state_nxt = ST_BMINIT;
      ST_BMINIT : state_nxt = eras_max ? ST_HOLD : ST_BMSTEP;  // locator full of erasures
      ST_BMSTEP : if (cnt_done) state_nxt = ST_HOLD;
      ST_HOLD   : if (loc_take) state_nxt = ST_WAIT;
      default   : state_nxt = ST_WAIT;
    endcase
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= ST_WAIT;
      bm_ready <= 1'b0;
      cnt      <= '0;
      cnt_done <= 1'b0;
    end else begin
      state    <= state_nxt;
      bm_ready <= (state_nxt == ST_WAIT);
      // step counter carries over from omega into BM steps
      if (state == ST_WAIT || state == ST_EDONE) begin
        cnt      <= CNT_W'(CHECK);
        cnt_done <= 1'b0;
      end else if (state == ST_EPOLY || state == ST_OMEGA || state == ST_BMSTEP) begin
        cnt      <= cnt - 1'b1;
        cnt_done <= (cnt <= 2);
      end
    end
  end

  // erasure decode, settles long before first use
  always_ff @(posedge iclk) begin
    eras_fail   <= (eras_num > CHECK);
    eras_zero   <= (eras_num == '0);
    eras_max    <= eras_fail || (eras_num == CHECK);
    cnt_r_level <= eras_fail ? CNT_W'(1) : CNT_W'(CHECK + 1 - int'(eras_num));
  end

  always_ff @(posedge iclk) begin
    case (state)
      ST_WAIT : if (syn_val) begin
        eras_num <= syn.eras_num;
        nonzero  <= syn.nonzero;
        cw       <= syn.cw;
        for (int i = 0; i < CHECK; i++) begin
          gamma[i]  <= syn.syndrome[i];
          tetta[i]  <= syn.syndrome[i];
          sh_reg[i] <= syn.eras_root[i];
        end
        gamma[CHECK] <= '0;
        tetta[CHECK] <= '0;
        for (int i = 0; i <= CHECK; i++) begin
          l_poly[i] <= (i == 0) ? sym_t'(1) : '0;
          b_poly[i] <= (i == 0) ? sym_t'(1) : '0;
        end
        sigma <= sym_t'(1);
        kv    <= '0;
      end
      ST_EPOLY : begin
        // multiply by (1 + root x), unused roots are zero
        for (int i = 1; i <= CHECK; i++)
          l_poly[i] <= l_poly[i] ^ gf_mult(sh_reg[0], l_poly[i-1]);
        for (int k = 0; k < CHECK - 1; k++)
          sh_reg[k] <= sh_reg[k+1];
        sh_reg[CHECK-1] <= '0;
      end
      ST_EDONE : begin
        b_poly <= l_poly;
        for (int k = 0; k < CHECK; k++)
          sh_reg[k] <= l_poly[k+1];  // erasure locator coeffs 1..CHECK
      end
      ST_OMEGA : begin
        for (int i = 0; i < CHECK; i++)
          gamma[i] <= gamma[i+1] ^ gf_mult(sh_reg[0], tetta[i]);
        for (int k = 0; k < CHECK - 1; k++)
          sh_reg[k] <= sh_reg[k+1];
        sh_reg[CHECK-1] <= '0;
      end
      ST_BMINIT : tetta <= gamma;
      ST_BMSTEP : begin
        l_poly[0] <= gf_mult(sigma, l_poly[0]);
        for (int i = 1; i <= CHECK; i++)
          l_poly[i] <= gf_mult(sigma, l_poly[i]) ^ gf_mult(gamma[0], b_poly[i-1]);
        for (int i = 0; i < CHECK; i++)
          gamma[i] <= gf_mult(sigma, gamma[i+1]) ^ gf_mult(gamma[0], tetta[i]);
        if (gamma[0] != '0 && !kv[M-1]) begin  // length change
          b_poly <= l_poly;
          for (int i = 0; i < CHECK; i++)
            tetta[i] <= gamma[i+1];
          sigma <= gamma[0];
          kv    <= ~kv;
        end else begin
          b_poly[0] <= '0;                       // times x
          for (int i = 1; i <= CHECK; i++)
            b_poly[i] <= b_poly[i-1];
          kv <= kv + 1'b1;
        end
      end
      default : ;
    endcase
  end

  assign loc_val = (state == ST_HOLD);

  always_comb begin
    for (int k = 0; k <= CHECK; k++)
      loc.loc_poly[k] = l_poly[k];
    for (int k = 0; k < CHECK; k++)
      loc.omega[k] = gamma[k];
    loc.eras_fail = eras_fail;
    loc.nonzero   = nonzero;
    loc.cw        = cw;
  end

endmodule

`default_nettype wire

// File: hw/rs_pkg.sv
//----------------------------------------
// rs decoder package
// field constants, GF(2^4) arithmetic, stage structs
//----------------------------------------
`default_nettype none

package rs_pkg;

  // field and code sizes
  localparam int M        = 4;   // symbol width
  localparam int N        = 15;  // codeword length
  localparam int CHECK    = 4;   // parity symbols
  localparam int IRRPOL   = 19;  // x^4 + x + 1
  localparam int GENSTART = 0;   // first generator root exponent
  localparam int CNT_W    = $clog2(CHECK + 1);

  // register map
  localparam logic [1:0] CFG_CTRL  = 2'd0;
  localparam logic [1:0] CFG_WORDS = 2'd1;
  localparam logic [1:0] CFG_FAILS = 2'd2;
  localparam logic [1:0] CFG_SYMS  = 2'd3;

  typedef logic [M-1:0] sym_t;

  // position 0 is the last symbol received
  typedef struct packed {
    sym_t [N-1:0] sym;
    logic [N-1:0] eras;
  } cw_t;

  typedef struct packed {
    sym_t [CHECK-1:0] syndrome;
    sym_t [CHECK-1:0] eras_root;  // ascending position
    logic [3:0]       eras_num;
    logic             nonzero;
    cw_t              cw;         // travels with the data
  } syn_t;

  typedef struct packed {
    sym_t [CHECK:0]   loc_poly;
    sym_t [CHECK-1:0] omega;
    logic             eras_fail;
    logic             nonzero;
    cw_t              cw;
  } loc_t;

  typedef struct packed {
    sym_t [N-1:0] data;
    logic         decfail;
    logic [3:0]   num_err;
    logic         nonzero;
  } res_t;

  typedef struct packed {
    logic       done;     // one cycle per word
    logic       decfail;
    logic [3:0] num_err;
  } stat_t;

  //----------------------------------------
  // GF(2^M) arithmetic
  //----------------------------------------

  function automatic sym_t gf_mult(sym_t a, sym_t b);
    logic [2*M-2:0] p;
    p = '0;
    for (int i = 0; i < M; i++)
      if (b[i]) p = p ^ ((2*M-1)'(a) << i);  // carryless product
    for (int i = 2*M-2; i >= M; i--)
      if (p[i]) p = p ^ (IRRPOL[2*M-2:0] << (i - M));  // fold back by field poly
    return p[M-1:0];
  endfunction

  // alpha^e with e taken mod N
  function automatic sym_t gf_alpha_pow(int e);
    int   re;
    sym_t r;
    re = e % N;
    if (re < 0) re = re + N;
    r = sym_t'(1);
    for (int i = 0; i < N; i++)
      if (i < re) r = gf_mult(r, sym_t'(2));
    return r;
  endfunction

  // a^(2^M-2), zero maps to zero
  function automatic sym_t gf_inv(sym_t a);
    sym_t r;
    r = sym_t'(1);
    for (int i = 0; i < (1 << M) - 2; i++)
      r = gf_mult(r, a);
    return r;
  endfunction

endpackage

`default_nettype wire

// File: hw/rs_syndrome.sv
//----------------------------------------
// syndrome stage
// input req/ack, horner syndromes, erasure roots
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rs_syndrome (
  input  logic         iclk,
  input  logic         ireset,
  input  logic         in_req,
  input  rs_pkg::cw_t  in_data,
  output logic         in_ack,
  input  logic         bm_ready,
  output logic         syn_val,
  output rs_pkg::syn_t syn
);
  import rs_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_CALC, ST_OFFER} state_t;

  state_t     state;
  logic [3:0] pos;              // symbol being folded in
  logic       start;
  cw_t        cw;
  sym_t       acc  [CHECK];     // horner accumulators
  sym_t       root [CHECK];
  logic [3:0] eras_num;

  // new word only with ack low and the last result gone
  assign start = (state == ST_IDLE) && in_req && !in_ack;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state  <= ST_IDLE;
      in_ack <= 1'b0;
      pos    <= '0;
    end else begin
      if (start) in_ack <= 1'b1;
      else if (!in_req) in_ack <= 1'b0;  // four-phase release
      case (state)
        ST_IDLE  : if (start) begin
          state <= ST_CALC;
          pos   <= 4'(N - 1);            // highest degree first
        end
        ST_CALC  : begin
          pos <= pos - 1'b1;
          if (pos == '0) state <= ST_OFFER;
        end
        ST_OFFER : if (bm_ready) state <= ST_IDLE;  // handed over
        default  : state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (start) begin
      cw       <= in_data;
      eras_num <= '0;
      for (int j = 0; j < CHECK; j++) begin
        acc[j]  <= '0;
        root[j] <= '0;
      end
    end else if (state == ST_CALC) begin
      // s_j = s_j * alpha^(GENSTART+j) + r_pos
      for (int j = 0; j < CHECK; j++)
        acc[j] <= gf_mult(acc[j], gf_alpha_pow(GENSTART + j)) ^ cw.sym[pos];
      if (cw.eras[pos]) begin
        root[0] <= gf_alpha_pow(int'(pos));  // lowest position ends up in front
        for (int k = 1; k < CHECK; k++)
          root[k] <= root[k-1];
        eras_num <= eras_num + 1'b1;
      end
    end
  end

  assign syn_val = (state == ST_OFFER) && bm_ready;

  always_comb begin
    syn.nonzero = 1'b0;
    for (int j = 0; j < CHECK; j++) begin
      syn.syndrome[j]  = acc[j];
      syn.eras_root[j] = root[j];
      if (acc[j] != '0) syn.nonzero = 1'b1;
    end
    syn.eras_num = eras_num;
    syn.cw       = cw;
  end

endmodule

`default_nettype wire

// File: list.f
hw/rs_pkg.sv
hw/rs_syndrome.sv
hw/rs_eras_berlekamp.sv
hw/rs_chien_forney.sv
hw/rs_decoder_regs.sv
hw/rs_decoder_top.sv
tests/rs_decoder_checker.sv
tests/tb_rs_decoder.sv

// File: tests/rs_decoder_checker.sv
//----------------------------------------
// handshake and reset assertions
// bound into the decoder top level
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rs_decoder_checker (
  input logic         iclk,
  input logic         ireset,
  input logic         in_req,
  input logic         in_ack,
  input logic         res_req,
  input rs_pkg::res_t res,
  input logic         res_ack
);

  // ack only ever answers a pending request
  ack_follows_req : assert property (@(posedge iclk) disable iff (ireset)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose while in_req was low");

  // result offered until the host acks it
  req_held : assert property (@(posedge iclk) disable iff (ireset)
    res_req && !res_ack |=> res_req)
    else $error("res_req dropped before res_ack");

  res_stable : assert property (@(posedge iclk) disable iff (ireset)
    res_req |=> !res_req || $stable(res))
    else $error("res changed while res_req was high");

  req_low_in_reset : assert property (@(posedge iclk) ireset |-> !res_req)
    else $error("res_req high during reset");

endmodule

bind rs_decoder_top rs_decoder_checker i_rs_decoder_checker (.*);

`default_nettype wire

// File: tests/tb_rs_decoder.sv
//----------------------------------------
// rs decoder testbench
// encoder, stimulus table, handshakes, checks
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rs_decoder;
  import rs_pkg::*;

  localparam int TMO = 400;                 // cycles per handshake wait
  localparam logic [31:0] SEED = 32'h608c946a;

  typedef sym_t [N-1:0] word_t;

  typedef struct packed {
    logic [31:0]  seed;     // message expansion seed
    logic [3:0]   e0pos;
    sym_t         e0val;    // zero means no error
    logic [3:0]   e1pos;
    sym_t         e1val;
    logic [N-1:0] eras;
    logic         corr_en;
    logic         exp_fail;
  } row_t;

  localparam row_t ROWS [9] = '{
    '{32'h1a2b3c4d, 4'd0,  4'h0, 4'd0, 4'h0, 15'h0000, 1'b1, 1'b0},  // clean
    '{32'h55aa1234, 4'd3,  4'h7, 4'd0, 4'h0, 15'h0000, 1'b1, 1'b0},  // one error
    '{32'hdeadbe01, 4'd14, 4'h1, 4'd6, 4'hc, 15'h0000, 1'b1, 1'b0},
    '{32'h0badf00d, 4'd0,  4'hf, 4'd1, 4'h3, 15'h0000, 1'b1, 1'b0},  // both in parity
    '{32'h13579bdf, 4'd0,  4'h0, 4'd0, 4'h0, 15'h1124, 1'b1, 1'b0},  // 4 erasures
    '{32'h2468ace0, 4'd9,  4'h5, 4'd0, 4'h0, 15'h2002, 1'b1, 1'b0},  // 2 eras + 1 err
    '{32'h7e57c0de, 4'd11, 4'ha, 4'd0, 4'h0, 15'h0080, 1'b1, 1'b0},
    '{32'hc001d00d, 4'd0,  4'h0, 4'd0, 4'h0, 15'h4249, 1'b1, 1'b1},  // 5 erasures
    '{32'h31415926, 4'd4,  4'h9, 4'd0, 4'h0, 15'h0000, 1'b0, 1'b0}   // correction off
  };

  localparam row_t PAIR [2] = '{
    '{32'h89abcdef, 4'd2,  4'h6, 4'd0, 4'h0, 15'h0000, 1'b1, 1'b0},
    '{32'h0f1e2d3c, 4'd13, 4'h4, 4'd5, 4'hb, 15'h0000, 1'b1, 1'b0}
  };

  logic         iclk, ireset;
  logic         in_req, in_ack;
  cw_t          in_data;
  logic         res_req, res_ack;
  res_t         res;
  logic         cfg_we;
  logic [1:0]   cfg_addr;
  logic [31:0]  cfg_wdata, cfg_rdata;

  int errors, checks, tests;
  int tot_words, tot_fails, tot_syms;        // expected counter totals
  bit timeout_hit;

  rs_decoder_top i_rs_decoder_top (.*);

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;
  end

  //----------------------------------------
  // reference field math and encoder
  //----------------------------------------
  function automatic sym_t field_mul(sym_t a, sym_t b);
    logic [M:0] x;
    sym_t       r;
    x = {1'b0, a};
    r = '0;
    for (int i = 0; i < M; i++) begin
      if (b[i]) r = r ^ x[M-1:0];
      x = x << 1;                              // times alpha
      if (x[M]) x = x ^ (M+1)'(IRRPOL);
    end
    return r;
  endfunction

  // systematic: message in positions N-1..CHECK, parity below
  function automatic word_t encode(logic [31:0] seed);
    logic [31:0] s;
    sym_t        gen [CHECK+1];
    sym_t        par [CHECK];
    sym_t        root, fb;
    word_t       w;
    s = seed | 32'h1;                          // xorshift never at zero
    gen[0] = sym_t'(1);
    for (int k = 1; k <= CHECK; k++) gen[k] = '0;
    root = sym_t'(1);
    for (int j = 0; j < GENSTART; j++) root = field_mul(root, sym_t'(2));
    for (int j = 0; j < CHECK; j++) begin
      for (int k = CHECK; k > 0; k--) gen[k] = gen[k-1] ^ field_mul(gen[k], root);
      gen[0] = field_mul(gen[0], root);
      root   = field_mul(root, sym_t'(2));
    end
    for (int k = 0; k < CHECK; k++) par[k] = '0;
    for (int i = N - 1; i >= CHECK; i--) begin
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      w[i] = s[3:0];
      fb = w[i] ^ par[CHECK-1];                // division by g(x)
      for (int k = CHECK - 1; k > 0; k--) par[k] = par[k-1] ^ field_mul(fb, gen[k]);
      par[0] = field_mul(fb, gen[0]);
    end
    for (int k = 0; k < CHECK; k++) w[k] = par[k];
    return w;
  endfunction

  task automatic build_word(input row_t t, output word_t orig, output word_t rx);
    orig = encode(t.seed);
    rx = orig;
    rx[t.e0pos] = rx[t.e0pos] ^ t.e0val;
    rx[t.e1pos] = rx[t.e1pos] ^ t.e1val;
    for (int i = 0; i < N; i++)
      if (t.eras[i]) rx[i] = sym_t'($urandom);   // erased, value unknown
  endtask

  //----------------------------------------
  // bus tasks
  //----------------------------------------
  task automatic send_word(input word_t w, input logic [N-1:0] mask);
    int n;
    @(posedge iclk);
    in_req       <= 1'b1;
    in_data.sym  <= w;
    in_data.eras <= mask;
    n = 0;
    while (!in_ack && n < TMO) begin
      @(posedge iclk);
      n++;
    end
    if (!in_ack) begin
      $display("timeout: DUT never raised in_ack");
      timeout_hit = 1'b1;
      return;
    end
    in_req <= 1'b0;
    n = 0;
    while (in_ack && n < TMO) begin
      @(posedge iclk);
      n++;
    end
    if (in_ack) begin
      $display("timeout: in_ack stuck high after in_req fell");
      timeout_hit = 1'b1;
    end
  endtask

  task automatic recv_word(input int delay, output res_t r);
    int n;
    n = 0;
    while (!res_req && n < TMO) begin
      @(posedge iclk);
      n++;
    end
    if (!res_req) begin
      $display("timeout: no result from DUT");
      timeout_hit = 1'b1;
      return;
    end
    r = res;
    repeat (delay) @(posedge iclk);
    res_ack <= 1'b1;
    n = 0;
    while (res_req && n < TMO) begin
      @(posedge iclk);
      n++;
    end
    res_ack <= 1'b0;
    if (res_req) begin
      $display("timeout: res_req stuck high after res_ack");
      timeout_hit = 1'b1;
    end
  endtask

  task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
    @(posedge iclk);
    cfg_we    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
    @(posedge iclk);
    cfg_we    <= 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] a, output logic [31:0] d);
    @(posedge iclk);
    cfg_addr <= a;
    @(posedge iclk);
    d = cfg_rdata;                             // combinational read, addr settled
  endtask

  //----------------------------------------
  // checks
  //----------------------------------------
  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got == exp) else begin
      $display("FAIL %s exp %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_result(input int id, input word_t orig, input word_t rx,
                              input logic en, input logic fail, input res_t r);
    int    ndiff;
    int    exp_cnt;
    int    errs_before;
    word_t exp_data;
    ndiff = 0;
    errs_before = errors;
    for (int i = 0; i < N; i++)
      if (rx[i] != orig[i]) ndiff++;
    exp_data = (fail || !en) ? rx : orig;      // uncorrected on fail or disable
    exp_cnt  = (fail || !en) ? 0 : ndiff;
    check_eq("res.data", 64'(exp_data), 64'(r.data));
    check_eq("res.decfail", 64'(fail), 64'(r.decfail));
    check_eq("res.num_err", 64'(exp_cnt), 64'(r.num_err));
    if (!fail) check_eq("res.nonzero", 64'(ndiff != 0), 64'(r.nonzero));
    tests++;
    tot_words++;
    tot_fails += int'(fail);
    tot_syms  += exp_cnt;
    $display("test %0d %s", id, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------
  initial begin
    word_t       orig, rx;
    word_t       p_orig [2];
    word_t       p_rx [2];
    res_t        r;
    res_t        rb [2];
    logic [31:0] v;
    void'($urandom(SEED));
    ireset    = 1'b1;
    in_req    = 1'b0;
    in_data   = '0;
    res_ack   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (8) @(posedge iclk);
    ireset <= 1'b0;

    for (int i = 0; i < 9 && !timeout_hit; i++) begin
      write_reg(CFG_CTRL, {31'b0, ROWS[i].corr_en});
      build_word(ROWS[i], orig, rx);
      send_word(rx, ROWS[i].eras);
      if (!timeout_hit) recv_word(0, r);
      if (!timeout_hit) check_result(i, orig, rx, ROWS[i].corr_en, ROWS[i].exp_fail, r);
    end

    // two words in flight, slow host on the result side
    if (!timeout_hit) begin
      write_reg(CFG_CTRL, 32'hffff_ffff);      // only bit 0 sticks
      for (int k = 0; k < 2; k++) build_word(PAIR[k], p_orig[k], p_rx[k]);
      fork
        begin
          send_word(p_rx[0], PAIR[0].eras);
          send_word(p_rx[1], PAIR[1].eras);
        end
        begin
          recv_word(int'($urandom % 6), rb[0]);
          recv_word(int'($urandom % 6), rb[1]);
        end
      join
    end
    if (!timeout_hit) begin
      for (int k = 0; k < 2; k++)
        check_result(9 + k, p_orig[k], p_rx[k], 1'b1, 1'b0, rb[k]);
      read_reg(CFG_CTRL, v);
      check_eq("cfg_rdata ctrl", 64'h1, 64'(v));
      read_reg(CFG_WORDS, v);
      check_eq("cfg_rdata words", 64'(tot_words), 64'(v));
      read_reg(CFG_FAILS, v);
      check_eq("cfg_rdata fails", 64'(tot_fails), 64'(v));
      read_reg(CFG_SYMS, v);
      check_eq("cfg_rdata syms", 64'(tot_syms), 64'(v));
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timeout_hit) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
